// File: source/bus_settings.svh
`default_nettype none

`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

// bus geometry, word addressed
`define BUS_AW 30
`define BUS_DW 32
`define BUS_SW 4

// on-chip RAM, 1024 words
`define RAM_AW 10

// memory map
`define MAP_REGION_HI 9
`define MAP_SYS_REGION 1
`define MAP_GPIO_ADDR 30'h400001

`define SYS_ID_VALUE 32'h20191028

`endif

`default_nettype wire

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // which slave the decoder steers a strobe to
    typedef enum logic [1:0] {
        SEL_NONE = 2'd0,
        SEL_MEM  = 2'd1,
        SEL_SYS  = 2'd2,
        SEL_GPIO = 2'd3
    } slave_sel_e;

    // system register index, low word-address bits
    typedef enum logic [3:0] {
        SYS_ID       = 4'd0,
        SYS_SCRATCH  = 4'd1,
        SYS_ERR_ADDR = 4'd2,
        SYS_UPTIME   = 4'd3,
        SYS_IRQ      = 4'd4
    } sys_reg_e;

endpackage : bus_pkg

`default_nettype wire

// File: source/wb_if.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

// pipelined wishbone, stall based
interface wb_if;
    logic               cyc;
    logic               stb;
    logic               we;
    logic [`BUS_AW-1:0] adr;
    logic [`BUS_DW-1:0] dat_w;
    logic [`BUS_SW-1:0] sel;

    logic               ack;
    logic               err;
    logic               stall;
    logic [`BUS_DW-1:0] dat_r;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  ack, err, stall, dat_r
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output ack, err, stall, dat_r
    );
endinterface : wb_if

`default_nettype wire

// File: source/wb_pri_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pri_arbiter (
    input  logic i_clk,
    input  logic i_rst,
    wb_if.slave  a,
    wb_if.slave  b,
    wb_if.master m
);

    // owner of the previous cycle, 1 means master b
    logic owner_b;
    logic grant_b;

    // owner holds the bus while its cyc stays up
    // otherwise a wins whenever it asks
    always_comb begin
        if (owner_b ? b.cyc : a.cyc) begin
            grant_b = owner_b;
        end else begin
            grant_b = b.cyc && !a.cyc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner_b <= 1'b0;
        end else begin
            owner_b <= grant_b;
        end
    end

    // request mux
    assign m.cyc   = grant_b ? b.cyc   : a.cyc;
    assign m.stb   = grant_b ? b.stb   : a.stb;
    assign m.we    = grant_b ? b.we    : a.we;
    assign m.adr   = grant_b ? b.adr   : a.adr;
    assign m.dat_w = grant_b ? b.dat_w : a.dat_w;
    assign m.sel   = grant_b ? b.sel   : a.sel;

    // the loser only sees stall
    assign a.stall = grant_b ? 1'b1 : m.stall;
    assign b.stall = grant_b ? m.stall : 1'b1;
    assign a.ack   = !grant_b && m.ack;
    assign b.ack   = grant_b && m.ack;
    assign a.err   = !grant_b && m.err;
    assign b.err   = grant_b && m.err;

    // read data is shared, ack qualifies it
    assign a.dat_r = m.dat_r;
    assign b.dat_r = m.dat_r;

    // a response lands on the master that was granted when it issued,
    // two cycles back, and that master still holds cyc
    resp_to_owner: assert property (@(posedge i_clk) disable iff (i_rst)
        (m.ack || m.err) |-> m.cyc && (grant_b == $past(grant_b, 2)))
        else $error("arbiter response routed away from its requester");

endmodule : wb_pri_arbiter

`default_nettype wire

// File: source/bus_decoder.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

module bus_decoder (
    input  logic               i_clk,
    input  logic               i_rst,
    wb_if.slave                m,
    wb_if.master               mem,
    wb_if.master               sys,
    wb_if.master               gpio,
    output logic               o_err_pulse,
    output logic [`BUS_AW-1:0] o_err_addr
);
    import bus_pkg::*;

    slave_sel_e               slv_sel;
    logic [`MAP_REGION_HI-1:0] region;
    logic                     none_req;
    logic                     ack_q;
    logic                     err_q1;
    logic                     err_q2;
    logic [`BUS_DW-1:0]       dat_q;
    logic [`BUS_AW-1:0]       err_addr_q;

    assign region = m.adr[`BUS_AW-1 -: `MAP_REGION_HI];

    // region decode first, then the exact device words
    always_comb begin
        if (region == '0) begin
            slv_sel = SEL_MEM;
        end else if (region == `MAP_REGION_HI'(`MAP_SYS_REGION)) begin
            slv_sel = SEL_SYS;
        end else if (m.adr == `MAP_GPIO_ADDR) begin
            slv_sel = SEL_GPIO;
        end else begin
            slv_sel = SEL_NONE;
        end
    end

    // request fans out, only the strobe is gated
    assign mem.cyc   = m.cyc;
    assign mem.stb   = m.stb && (slv_sel == SEL_MEM);
    assign mem.we    = m.we;
    assign mem.adr   = m.adr;
    assign mem.dat_w = m.dat_w;
    assign mem.sel   = m.sel;

    assign sys.cyc   = m.cyc;
    assign sys.stb   = m.stb && (slv_sel == SEL_SYS);
    assign sys.we    = m.we;
    assign sys.adr   = m.adr;
    assign sys.dat_w = m.dat_w;
    assign sys.sel   = m.sel;

    assign gpio.cyc   = m.cyc;
    assign gpio.stb   = m.stb && (slv_sel == SEL_GPIO);
    assign gpio.we    = m.we;
    assign gpio.adr   = m.adr;
    assign gpio.dat_w = m.dat_w;
    assign gpio.sel   = m.sel;

    assign m.stall = ((slv_sel == SEL_MEM) && mem.stall)
                  || ((slv_sel == SEL_SYS) && sys.stall)
                  || ((slv_sel == SEL_GPIO) && gpio.stall);

    assign none_req = m.stb && !m.stall && (slv_sel == SEL_NONE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q  <= 1'b0;
            err_q1 <= 1'b0;
            err_q2 <= 1'b0;
        end else begin
            ack_q  <= mem.ack || sys.ack || gpio.ack;
            // unmapped err takes an extra stage to match the slave path
            err_q1 <= none_req;
            err_q2 <= err_q1 || mem.err || sys.err || gpio.err;
        end
    end

    always_ff @(posedge i_clk) begin
        if (sys.ack) begin
            dat_q <= sys.dat_r;
        end else if (mem.ack) begin
            dat_q <= mem.dat_r;
        end else if (gpio.ack) begin
            dat_q <= gpio.dat_r;
        end else begin
            dat_q <= '0;
        end
        if (none_req) begin
            err_addr_q <= m.adr;
        end
    end

    assign m.ack   = ack_q;
    assign m.err   = err_q2;
    assign m.dat_r = dat_q;

    assign o_err_pulse = err_q1;
    assign o_err_addr  = err_addr_q;

    one_slave_ack: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0({mem.ack, sys.ack, gpio.ack}))
        else $error("more than one slave acked in the same cycle");

endmodule : bus_decoder

`default_nettype wire

// File: source/sys_regs.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

module sys_regs (
    input  logic               i_clk,
    input  logic               i_rst,
    wb_if.slave                s,
    input  logic               i_err_pulse,
    input  logic [`BUS_AW-1:0] i_err_addr,
    output logic               o_irq
);
    import bus_pkg::*;

    sys_reg_e           reg_idx;
    logic [`BUS_DW-1:0] scratch;
    logic [`BUS_DW-1:0] uptime;
    logic [`BUS_AW-1:0] err_addr;
    logic               irq;
    logic               ack;
    logic [`BUS_DW-1:0] rd_data;

    assign reg_idx = sys_reg_e'(s.adr[3:0]);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack      <= 1'b0;
            irq      <= 1'b0;
            uptime   <= '0;
            err_addr <= '0;
        end else begin
            ack <= s.stb;
            if (s.stb && s.we && (reg_idx == SYS_IRQ)) begin
                irq <= s.dat_w[0];
            end
            // top bit is sticky, the rest wraps
            if (!uptime[`BUS_DW-1]) begin
                uptime <= uptime + 1'b1;
            end else begin
                uptime[`BUS_DW-2:0] <= uptime[`BUS_DW-2:0] + 1'b1;
            end
            if (i_err_pulse) begin
                err_addr <= i_err_addr;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (s.stb && s.we && (reg_idx == SYS_SCRATCH)) begin
            scratch <= s.dat_w;
        end
    end

    always_ff @(posedge i_clk) begin
        case (reg_idx)
            SYS_ID:       rd_data <= `SYS_ID_VALUE;
            SYS_SCRATCH:  rd_data <= scratch;
            // byte address for software
            SYS_ERR_ADDR: rd_data <= {err_addr, 2'b00};
            SYS_UPTIME:   rd_data <= uptime;
            SYS_IRQ:      rd_data <= {{(`BUS_DW-1){1'b0}}, irq};
            default:      rd_data <= '0;
        endcase
    end

    assign s.ack   = ack;
    assign s.err   = 1'b0;
    assign s.stall = 1'b0;
    assign s.dat_r = rd_data;
    assign o_irq   = irq;

endmodule : sys_regs

`default_nettype wire

// File: source/wb_ram.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

module wb_ram (
    input logic i_clk,
    wb_if.slave s
);

    logic [`BUS_DW-1:0] mem [0:(2**`RAM_AW)-1];
    logic [`RAM_AW-1:0] word_idx;
    logic [`BUS_DW-1:0] rd_data;
    logic               ack;

    // upper address bits ignored, region aliases
    assign word_idx = s.adr[`RAM_AW-1:0];

    always_ff @(posedge i_clk) begin
        ack <= s.stb;
        if (s.stb && s.we) begin
            for (int i = 0; i < `BUS_SW; i++) begin
                if (s.sel[i]) begin
                    mem[word_idx][8*i +: 8] <= s.dat_w[8*i +: 8];
                end
            end
        end
        rd_data <= mem[word_idx];
    end

    assign s.ack   = ack;
    assign s.err   = 1'b0;
    assign s.stall = 1'b0;
    assign s.dat_r = rd_data;

endmodule : wb_ram

`default_nettype wire

// File: source/gpio_port.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

module gpio_port (
    input  logic        i_clk,
    input  logic        i_rst,
    wb_if.slave         s,
    input  logic [15:0] i_switches,
    output logic [15:0] o_leds
);

    logic [15:0]        leds;
    logic               ack;
    logic [`BUS_DW-1:0] rd_data;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            leds <= '0;
            ack  <= 1'b0;
        end else begin
            ack <= s.stb;
            if (s.stb && s.we) begin
                leds <= s.dat_w[15:0];
            end
        end
    end

    // switches high, leds low
    always_ff @(posedge i_clk) begin
        rd_data <= {i_switches, leds};
    end

    assign s.ack   = ack;
    assign s.err   = 1'b0;
    assign s.stall = 1'b0;
    assign s.dat_r = rd_data;
    assign o_leds  = leds;

endmodule : gpio_port

`default_nettype wire

// File: source/soc_bus_top.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

module soc_bus_top (
    input  logic               i_clk,
    input  logic               i_rst,
    // core master, high priority
    input  logic               i_a_cyc,
    input  logic               i_a_stb,
    input  logic               i_a_we,
    input  logic [`BUS_AW-1:0] i_a_adr,
    input  logic [`BUS_DW-1:0] i_a_dat,
    input  logic [`BUS_SW-1:0] i_a_sel,
    output logic               o_a_ack,
    output logic               o_a_err,
    output logic               o_a_stall,
    output logic [`BUS_DW-1:0] o_a_dat,
    // debug master
    input  logic               i_b_cyc,
    input  logic               i_b_stb,
    input  logic               i_b_we,
    input  logic [`BUS_AW-1:0] i_b_adr,
    input  logic [`BUS_DW-1:0] i_b_dat,
    input  logic [`BUS_SW-1:0] i_b_sel,
    output logic               o_b_ack,
    output logic               o_b_err,
    output logic               o_b_stall,
    output logic [`BUS_DW-1:0] o_b_dat,
    input  logic [15:0]        i_switches,
    output logic [15:0]        o_leds,
    output logic               o_irq
);

    logic               err_pulse;
    logic [`BUS_AW-1:0] err_addr;

    wb_if a_bus ();
    wb_if b_bus ();
    wb_if arb_bus ();
    wb_if mem_bus ();
    wb_if sys_bus ();
    wb_if gpio_bus ();

    // plain ports onto the master-side buses
    assign a_bus.cyc   = i_a_cyc;
    assign a_bus.stb   = i_a_stb;
    assign a_bus.we    = i_a_we;
    assign a_bus.adr   = i_a_adr;
    assign a_bus.dat_w = i_a_dat;
    assign a_bus.sel   = i_a_sel;
    assign o_a_ack     = a_bus.ack;
    assign o_a_err     = a_bus.err;
    assign o_a_stall   = a_bus.stall;
    assign o_a_dat     = a_bus.dat_r;

    assign b_bus.cyc   = i_b_cyc;
    assign b_bus.stb   = i_b_stb;
    assign b_bus.we    = i_b_we;
    assign b_bus.adr   = i_b_adr;
    assign b_bus.dat_w = i_b_dat;
    assign b_bus.sel   = i_b_sel;
    assign o_b_ack     = b_bus.ack;
    assign o_b_err     = b_bus.err;
    assign o_b_stall   = b_bus.stall;
    assign o_b_dat     = b_bus.dat_r;

    wb_pri_arbiter arb_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .a     (a_bus.slave),
        .b     (b_bus.slave),
        .m     (arb_bus.master)
    );

    bus_decoder dec_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .m           (arb_bus.slave),
        .mem         (mem_bus.master),
        .sys         (sys_bus.master),
        .gpio        (gpio_bus.master),
        .o_err_pulse (err_pulse),
        .o_err_addr  (err_addr)
    );

    wb_ram ram_i (
        .i_clk (i_clk),
        .s     (mem_bus.slave)
    );

    sys_regs sys_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .s           (sys_bus.slave),
        .i_err_pulse (err_pulse),
        .i_err_addr  (err_addr),
        .o_irq       (o_irq)
    );

    gpio_port gpio_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .s          (gpio_bus.slave),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule : soc_bus_top

`default_nettype wire

// File: bench/soc_bus_tb.sv
`timescale 1ns/1ps
`include "bus_settings.svh"
`default_nettype none

module soc_bus_tb;
    import bus_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic               i_clk;
    logic               i_rst;
    logic [1:0]         cyc;
    logic [1:0]         stb;
    logic [1:0]         we;
    logic [`BUS_AW-1:0] adr [2];
    logic [`BUS_DW-1:0] wdat [2];
    logic [`BUS_SW-1:0] sel [2];
    logic [1:0]         ack;
    logic [1:0]         err;
    logic [1:0]         stall;
    logic [`BUS_DW-1:0] rdat [2];
    logic [15:0]        i_switches;
    logic [15:0]        o_leds;
    logic               o_irq;

    int checks = 0;
    int errors = 0;
    int timeouts = 0;
    int edge_cnt = 0;
    int seed = 11909;

    soc_bus_top dut_i (
        .i_clk (i_clk), .i_rst (i_rst),
        .i_a_cyc (cyc[0]), .i_a_stb (stb[0]), .i_a_we (we[0]), .i_a_adr (adr[0]),
        .i_a_dat (wdat[0]), .i_a_sel (sel[0]), .o_a_ack (ack[0]), .o_a_err (err[0]),
        .o_a_stall (stall[0]), .o_a_dat (rdat[0]),
        .i_b_cyc (cyc[1]), .i_b_stb (stb[1]), .i_b_we (we[1]), .i_b_adr (adr[1]),
        .i_b_dat (wdat[1]), .i_b_sel (sel[1]), .o_b_ack (ack[1]), .o_b_err (err[1]),
        .o_b_stall (stall[1]), .o_b_dat (rdat[1]),
        .i_switches (i_switches), .o_leds (o_leds), .o_irq (o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // edge index, used to measure response latency
    always @(posedge i_clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %0s", what);
        timeouts++;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("Error: %0s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    // one request, hold it through stall, then wait for the response
    task automatic bus_access(input int m, input logic w, input logic [29:0] a,
                              input logic [31:0] d, input logic [3:0] s,
                              output logic [31:0] q, output logic e, output logic k,
                              output int lat);
        int n;
        int acc;
        q = '0;
        e = 1'b0;
        k = 1'b0;
        lat = 0;
        @(negedge i_clk);
        cyc[m] = 1'b1;
        stb[m] = 1'b1;
        we[m] = w;
        adr[m] = a;
        wdat[m] = d;
        sel[m] = s;
        n = 0;
        #1;
        while (stall[m] && n <= WAIT_LIMIT) begin
            @(negedge i_clk);
            #1;
            n++;
        end
        acc = edge_cnt + 1;
        if (stall[m]) begin
            report_timeout("stall to fall");
        end else begin
            n = 0;
            do begin
                @(negedge i_clk);
                stb[m] = 1'b0;
                n++;
            end while (!(ack[m] || err[m]) && n <= WAIT_LIMIT);
            if (!(ack[m] || err[m])) begin
                report_timeout("ack or err");
            end else begin
                q = rdat[m];
                e = err[m];
                k = ack[m];
                // the response is sampled at the coming rising edge
                lat = edge_cnt + 1 - acc;
                // cyc stays up through that edge
                @(negedge i_clk);
            end
        end
        cyc[m] = 1'b0;
        stb[m] = 1'b0;
        we[m] = 1'b0;
    endtask

    // four reads on master a without waiting for responses
    task automatic burst_read(input string name, input logic [29:0] a, input logic [31:0] exp);
        int acc [4];
        int got;
        int n;
        int waits;
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    @(negedge i_clk);
                    cyc[0] = 1'b1;
                    stb[0] = 1'b1;
                    we[0] = 1'b0;
                    adr[0] = a + k;
                    sel[0] = 4'hf;
                    n = 0;
                    #1;
                    while (stall[0] && n <= WAIT_LIMIT) begin
                        @(negedge i_clk);
                        #1;
                        n++;
                    end
                    if (stall[0]) begin
                        report_timeout("burst stall to fall");
                        break;
                    end
                    acc[k] = edge_cnt + 1;
                end
                @(negedge i_clk);
                stb[0] = 1'b0;
            end
            begin
                got = 0;
                waits = 0;
                while (got < 4 && waits <= WAIT_LIMIT) begin
                    @(negedge i_clk);
                    waits++;
                    if (ack[0]) begin
                        check_val(name, exp + got, rdat[0]);
                        check_val({name, "_latency"}, acc[got] + 2, edge_cnt + 1);
                        got++;
                    end
                end
                if (got < 4) begin
                    report_timeout("burst acks");
                end
            end
        join
        // last response is sampled at the next rising edge
        @(negedge i_clk);
        cyc[0] = 1'b0;
    endtask

    initial begin
        string       line;
        string       name;
        string       mst;
        string       op;
        logic [29:0] a_v;
        logic [31:0] wd;
        logic [3:0]  sl;
        logic [31:0] ex;
        int          ee;
        int          fd;
        int          m;
        int          lat;
        int          lat_b;
        logic [31:0] q;
        logic [31:0] q_b;
        logic        e;
        logic        e_b;
        logic        k;
        logic        k_b;
        logic [31:0] last_up;
        realtime     t_a;
        realtime     t_b;

        i_rst = 1'b1;
        cyc = '0;
        stb = '0;
        we = '0;
        for (int i = 0; i < 2; i++) begin
            adr[i] = '0;
            wdat[i] = '0;
            sel[i] = '0;
        end
        i_switches = 16'($random(seed));
        last_up = '0;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        check_val("reset_outputs", 32'h0, {ack, err, o_irq, o_leds});

        fd = $fopen("bench/bus_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/bus_cases.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd) && timeouts == 0) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            if ($sscanf(line, "%s %s %s %h %h %h %h %d", name, mst, op, a_v, wd, sl, ex, ee)
                    != 8) begin
                $display("malformed line in bench/bus_cases.txt: %0s", line);
                errors++;
                continue;
            end
            m = (mst == "b") ? 1 : 0;
            if (op == "w" || op == "r" || op == "g" || op == "u") begin
                bus_access(m, op == "w", a_v, wd, sl, q, e, k, lat);
                if (timeouts != 0) break;
                check_val({name, "_err"}, ee, e);
                check_val({name, "_ack"}, !ee, k);
                check_val({name, "_latency"}, 2, lat);
                if (op == "r" && !ee) check_val(name, ex, q);
                if (op == "g") check_val(name, {i_switches, ex[15:0]}, q);
                if (op == "u") begin
                    checks++;
                    assert (q > last_up) else begin
                        $display("Error: %0s expected above %h actual %h", name, last_up, q);
                        errors++;
                    end
                    last_up = q;
                end
            end else if (op == "i") begin
                @(negedge i_clk);
                check_val(name, ex, o_irq);
            end else if (op == "l") begin
                @(negedge i_clk);
                check_val(name, ex, o_leds);
            end else if (op == "p") begin
                fork
                    begin
                        bus_access(0, 1'b0, a_v, wd, sl, q, e, k, lat);
                        t_a = $realtime;
                    end
                    begin
                        bus_access(1, 1'b0, a_v, wd, sl, q_b, e_b, k_b, lat_b);
                        t_b = $realtime;
                    end
                    begin
                        // a wins, b is held off
                        @(negedge i_clk);
                        #1;
                        check_val({name, "_stall"}, 2'b10, stall);
                    end
                join
                if (timeouts != 0) break;
                check_val({name, "_a"}, ex, q);
                check_val({name, "_b"}, ex, q_b);
                check_val({name, "_a_err"}, ee, e);
                check_val({name, "_b_err"}, ee, e_b);
                check_val({name, "_a_ack"}, !ee, k);
                check_val({name, "_b_ack"}, !ee, k_b);
                check_val({name, "_a_latency"}, 2, lat);
                check_val({name, "_b_latency"}, 2, lat_b);
                checks++;
                assert (t_a < t_b) else begin
                    $display("master b was answered before master a in %0s", name);
                    errors++;
                end
            end else if (op == "b") begin
                burst_read(name, a_v, ex);
            end else begin
                $display("unknown operation %0s in case %0s", op, name);
                errors++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        finish_run();
    end

endmodule : soc_bus_tb

`default_nettype wire

// File: bench/bus_cases.txt
# name master op word_addr wdata sel expect err_flag
# op: w write, r read, g gpio read, u uptime, i irq pin, l led pins, p a+b read, b burst
reset_irq a i 0 0 f 00000000 0
ram_full_5 a w 00000005 11223344 f 00000000 0
ram_rd_5 a r 00000005 00000000 f 11223344 0
ram_byte1_5 a w 00000005 aabbccdd 2 00000000 0
ram_merge_5 a r 00000005 00000000 f 1122cc44 0
ram_alias_405 b r 00000405 00000000 f 1122cc44 0
ram_full_123 b w 00000123 00000000 f 00000000 0
ram_ends_123 b w 00000123 deadbeef 9 00000000 0
ram_merge_123 a r 00000123 00000000 f de0000ef 0
ram_full_3ff a w 000003ff 12345678 f 00000000 0
ram_half_3ff a w 000003ff 55660000 c 00000000 0
ram_alias_7ff b r 000007ff 00000000 f 55665678 0
sys_id a r 00200000 00000000 f 20191028 0
sys_scratch_w b w 00200001 cafef00d f 00000000 0
sys_scratch_r a r 00200001 00000000 f cafef00d 0
sys_irq_set a w 00200004 00000001 f 00000000 0
sys_irq_high a i 0 0 f 00000001 0
sys_irq_rd a r 00200004 00000000 f 00000001 0
sys_irq_clr b w 00200004 00000000 f 00000000 0
sys_irq_low a i 0 0 f 00000000 0
sys_uptime_1 a u 00200003 00000000 f 00000000 0
sys_uptime_2 b u 00200003 00000000 f 00000000 0
gpio_led_w a w 00400001 0000a5a5 f 00000000 0
gpio_led_pins a l 0 0 f 0000a5a5 0
gpio_rd b g 00400001 00000000 f 0000a5a5 0
unmapped_rd a r 00400002 00000000 f 00000000 1
err_addr_1 a r 00200002 00000000 f 01000008 0
unmapped_wr b w 03000000 12345678 f 00000000 1
err_addr_2 b r 00200002 00000000 f 0c000000 0
burst_w0 a w 00000010 a0000010 f 00000000 0
burst_w1 a w 00000011 a0000011 f 00000000 0
burst_w2 b w 00000012 a0000012 f 00000000 0
burst_w3 b w 00000013 a0000013 f 00000000 0
arb_both a p 00000005 00000000 f 1122cc44 0
burst_rd a b 00000010 00000000 f a0000010 0

// File: list.f
+incdir+source
source/bus_pkg.sv
source/wb_if.sv
source/wb_pri_arbiter.sv
source/bus_decoder.sv
source/sys_regs.sv
source/wb_ram.sv
source/gpio_port.sv
source/soc_bus_top.sv
bench/soc_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the bus testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module soc_bus_tb -f list.f -o soc_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/soc_bus_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation run failed"
    exit 1
fi

cat "$LOG"

if grep -qx "No errors" "$LOG"; then
    exit 0
else
    exit 1
fi
